// ==== design/ids_pkt_pkg.sv ====
package ids_pkt_pkg;

	// datapath word layout
	localparam int DATA_WIDTH = 64;
	localparam int CTRL_WIDTH = 8;

	// header layout
	localparam int HDR_WORDS = 5;   // zero-ctrl words after the start word
	localparam int IP_WORD   = 4;   // header word holding the source ip
	localparam int IP_LSB    = 16;  // ip sits in bits 47:16

	// payload search
	localparam int PATTERN_BYTES = 7;

	typedef logic [31:0] ip_addr_t;

	// one stream word, ctrl byte on top
	typedef struct packed {
		logic [CTRL_WIDTH-1:0] ctrl;
		logic [DATA_WIDTH-1:0] data;
	} pkt_word_t;

endpackage

// ==== design/ids_reg_pkg.sv ====
package ids_reg_pkg;

	localparam int REG_ADDR_WIDTH = 4;
	localparam int REG_DATA_WIDTH = 32;

	localparam int FT_DEPTH      = 16;
	localparam int FT_ADDR_WIDTH = 4;

	// register map, word addresses
	localparam logic [REG_ADDR_WIDTH-1:0] REG_PATTERN_HIGH    = 4'd0;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_PATTERN_LOW     = 4'd1;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_FT_IP           = 4'd2;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_FT_ENTRY        = 4'd3;  // write commits staged ip
	localparam logic [REG_ADDR_WIDTH-1:0] REG_COUNT_SEL       = 4'd4;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_NUM_PACKETS     = 4'd8;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_PATTERN_MATCHES = 4'd9;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_FLOW_HITS       = 4'd10;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_ENTRY_COUNT     = 4'd11;

	typedef struct packed {
		logic                      req;
		logic                      rd_wr_l;  // 1 = read
		logic [REG_ADDR_WIDTH-1:0] addr;
		logic [REG_DATA_WIDTH-1:0] wdata;
	} reg_req_t;

	// flow table write from the register block
	typedef struct packed {
		logic                     we;
		logic [FT_ADDR_WIDTH-1:0] index;
		logic                     valid;
		logic [31:0]              ip;
	} ft_write_t;

endpackage

// ==== design/ids_input_fifo.sv ====
`timescale 1ns/1ns

module ids_input_fifo import ids_pkt_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  pkt_word_t wr_word,
	input  logic      wr_en,
	input  logic      rd_en,
	output pkt_word_t head,
	output logic      empty,
	output logic      nearly_full
);

	pkt_word_t  mem [0:3];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] count;  // 0..4
	logic       full;

	assign head        = mem[rd_ptr];  // fall-through, head visible before read
	assign empty       = (count == 3'd0);
	assign full        = (count == 3'd4);
	assign nearly_full = (count >= 3'd3);  // one spare slot for a late write

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + {1'b0, wr_en};
			rd_ptr <= rd_ptr + {1'b0, rd_en};
			count  <= count + {2'b00, wr_en} - {2'b00, rd_en};
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(wr_en && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(rd_en && empty));

endmodule

// ==== design/ids_pkt_parser.sv ====
`timescale 1ns/1ns

module ids_pkt_parser import ids_pkt_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  pkt_word_t             head,
	input  logic                  empty,
	output logic                  rd_en,
	input  logic                  out_rdy,
	output pkt_word_t             out_word,
	output logic                  out_wr,
	output logic [DATA_WIDTH-1:0] scan_word,
	output logic                  scan_valid,
	output logic                  pkt_end,
	output logic                  lookup,
	output ip_addr_t              lookup_ip
);

	typedef enum logic [1:0] {
		ST_START,
		ST_HEADER,
		ST_PAYLOAD
	} state_t;

	state_t     state;
	logic [2:0] hdr_cnt;
	logic [2:0] hdr_cnt_inc;
	logic       ctrl_zero;

	assign rd_en       = !empty && out_rdy;
	assign ctrl_zero   = (head.ctrl == '0);
	assign hdr_cnt_inc = hdr_cnt + 3'd1;

	// events come out together with the word on out_wr
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_START;
			hdr_cnt    <= '0;
			out_wr     <= 1'b0;
			scan_valid <= 1'b0;
			pkt_end    <= 1'b0;
			lookup     <= 1'b0;
		end else begin
			out_wr     <= rd_en;
			scan_valid <= 1'b0;
			pkt_end    <= 1'b0;
			lookup     <= 1'b0;
			if (rd_en) begin
				case (state)
					ST_START: begin
						if (!ctrl_zero) begin  // start word
							state   <= ST_HEADER;
							hdr_cnt <= '0;
						end
					end
					ST_HEADER: begin
						if (ctrl_zero) begin
							hdr_cnt <= hdr_cnt_inc;
							if (hdr_cnt_inc == 3'(IP_WORD))
								lookup <= 1'b1;
							if (hdr_cnt_inc == 3'(HDR_WORDS))
								state <= ST_PAYLOAD;
						end
					end
					ST_PAYLOAD: begin
						if (ctrl_zero) begin
							scan_valid <= 1'b1;
						end else begin
							pkt_end <= 1'b1;  // end word
							state   <= ST_START;
						end
					end
					default: state <= ST_START;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			out_word  <= head;
			scan_word <= head.data;
			lookup_ip <= head.data[IP_LSB +: $bits(ip_addr_t)];
		end
	end

	// payload only after the full header
	a_payload_after_header: assert property (@(posedge clk) disable iff (reset)
		state == ST_PAYLOAD |-> hdr_cnt == 3'(HDR_WORDS));

endmodule

// ==== design/ids_pattern_matcher.sv ====
`timescale 1ns/1ns

module ids_pattern_matcher import ids_pkt_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [PATTERN_BYTES*8-1:0] pattern,
	input  logic [DATA_WIDTH-1:0]      scan_word,
	input  logic                       scan_valid,
	input  logic                       pkt_end,
	output logic                       pattern_hit
);

	logic [DATA_WIDTH-1:0]   prev_word;
	logic                    prev_valid;  // prev_word belongs to this payload
	logic [2*DATA_WIDTH-1:0] window;
	logic [DATA_WIDTH/8-1:0] hit_at;
	logic                    found;

	// earliest byte at the top of the window
	assign window = {prev_word, scan_word};

	// offsets that end inside the current word
	// the first PATTERN_BYTES-1 of them reach back into prev_word
	always_comb begin
		for (int j = 0; j < DATA_WIDTH/8; j++) begin
			hit_at[j] = (window[2*DATA_WIDTH-1-8*(j+DATA_WIDTH/8+1-PATTERN_BYTES)
				-: PATTERN_BYTES*8] == pattern) && (prev_valid || j >= PATTERN_BYTES-1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prev_valid  <= 1'b0;
			found       <= 1'b0;
			pattern_hit <= 1'b0;
		end else begin
			pattern_hit <= pkt_end && found;  // one count per packet
			if (pkt_end) begin
				found      <= 1'b0;
				prev_valid <= 1'b0;
			end else if (scan_valid) begin
				found      <= found || (|hit_at);
				prev_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan_valid)
			prev_word <= scan_word;
	end

endmodule

// ==== design/ids_flow_table.sv ====
`timescale 1ns/1ns

module ids_flow_table import ids_pkt_pkg::*, ids_reg_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  ft_write_t                 ft_wr,
	input  logic                      lookup,
	input  ip_addr_t                  lookup_ip,
	input  logic [FT_ADDR_WIDTH-1:0]  count_sel,
	output logic [REG_DATA_WIDTH-1:0] entry_count,
	output logic [REG_DATA_WIDTH-1:0] hit_total
);

	logic [FT_DEPTH-1:0]       ft_valid;
	ip_addr_t                  ft_ip [FT_DEPTH];
	logic [REG_DATA_WIDTH-1:0] hit_cnt [FT_DEPTH];
	logic [FT_DEPTH-1:0]       ip_match;

	// all entries compared at once
	always_comb begin
		for (int i = 0; i < FT_DEPTH; i++)
			ip_match[i] = ft_valid[i] && (ft_ip[i] == lookup_ip);
	end

	assign entry_count = hit_cnt[count_sel];

	always_ff @(posedge clk) begin
		if (ft_wr.we)
			ft_ip[ft_wr.index] <= ft_wr.ip;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ft_valid  <= '0;
			hit_total <= '0;
			for (int i = 0; i < FT_DEPTH; i++)
				hit_cnt[i] <= '0;
		end else begin
			if (lookup && (|ip_match))
				hit_total <= hit_total + 1'b1;  // once per packet
			for (int i = 0; i < FT_DEPTH; i++) begin
				if (ft_wr.we && ft_wr.index == FT_ADDR_WIDTH'(i)) begin
					// rewritten entry starts counting afresh
					ft_valid[i] <= ft_wr.valid;
					hit_cnt[i]  <= '0;
				end else if (lookup && ip_match[i]) begin
					hit_cnt[i] <= hit_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// ==== design/ids_regs.sv ====
`timescale 1ns/1ns

module ids_regs import ids_pkt_pkg::*, ids_reg_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  reg_req_t                   reg_in,
	output logic                       reg_ack,
	output logic [REG_DATA_WIDTH-1:0]  reg_rdata,
	output logic [PATTERN_BYTES*8-1:0] pattern,
	output ft_write_t                  ft_wr,
	output logic [FT_ADDR_WIDTH-1:0]   count_sel,
	input  logic                       pkt_end,
	input  logic                       pattern_hit,
	input  logic [REG_DATA_WIDTH-1:0]  entry_count,
	input  logic [REG_DATA_WIDTH-1:0]  hit_total
);

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACCESS,
		HS_ACK
	} hs_state_t;

	hs_state_t                 hs_state;
	logic [REG_DATA_WIDTH-1:0] pattern_high;
	logic [REG_DATA_WIDTH-1:0] pattern_low;
	logic [REG_DATA_WIDTH-1:0] ft_ip_stage;
	logic [REG_DATA_WIDTH-1:0] num_packets;
	logic [REG_DATA_WIDTH-1:0] pattern_matches;
	logic [REG_DATA_WIDTH-1:0] rd_value;
	logic                      do_access;
	logic                      do_write;

	assign do_access = (hs_state == HS_IDLE) && reg_in.req;  // once per handshake
	assign do_write  = do_access && !reg_in.rd_wr_l;
	assign pattern   = {pattern_high[PATTERN_BYTES*8-REG_DATA_WIDTH-1:0], pattern_low};

	always_comb begin
		case (reg_in.addr)
			REG_PATTERN_HIGH:    rd_value = pattern_high;
			REG_PATTERN_LOW:     rd_value = pattern_low;
			REG_FT_IP:           rd_value = ft_ip_stage;
			REG_FT_ENTRY:        rd_value = REG_DATA_WIDTH'({ft_wr.valid, ft_wr.index});
			REG_COUNT_SEL:       rd_value = REG_DATA_WIDTH'(count_sel);
			REG_NUM_PACKETS:     rd_value = num_packets;
			REG_PATTERN_MATCHES: rd_value = pattern_matches;
			REG_FLOW_HITS:       rd_value = hit_total;
			REG_ENTRY_COUNT:     rd_value = entry_count;
			default:             rd_value = '0;  // unmapped
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hs_state        <= HS_IDLE;
			reg_ack         <= 1'b0;
			pattern_high    <= '0;
			pattern_low     <= '0;
			ft_ip_stage     <= '0;
			ft_wr           <= '0;
			count_sel       <= '0;
			num_packets     <= '0;
			pattern_matches <= '0;
		end else begin
			ft_wr.we <= 1'b0;
			case (hs_state)
				HS_IDLE:   if (reg_in.req) hs_state <= HS_ACCESS;
				HS_ACCESS: begin
					reg_ack  <= 1'b1;
					hs_state <= HS_ACK;
				end
				default: begin
					if (!reg_in.req) begin  // host released req
						reg_ack  <= 1'b0;
						hs_state <= HS_IDLE;
					end
				end
			endcase
			if (do_write) begin
				case (reg_in.addr)
					REG_PATTERN_HIGH: pattern_high <= reg_in.wdata;
					REG_PATTERN_LOW:  pattern_low  <= reg_in.wdata;
					REG_FT_IP:        ft_ip_stage  <= reg_in.wdata;
					REG_FT_ENTRY: begin
						ft_wr.we    <= 1'b1;
						ft_wr.index <= reg_in.wdata[FT_ADDR_WIDTH-1:0];
						ft_wr.valid <= reg_in.wdata[FT_ADDR_WIDTH];
						ft_wr.ip    <= ft_ip_stage;
					end
					REG_COUNT_SEL: count_sel <= reg_in.wdata[FT_ADDR_WIDTH-1:0];
					default: ;
				endcase
			end
			if (pkt_end)
				num_packets <= num_packets + 1'b1;
			if (pattern_hit)
				pattern_matches <= pattern_matches + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_access && reg_in.rd_wr_l)
			reg_rdata <= rd_value;  // held until the next read
	end

	// req must still be high in the cycle where reg_ack goes up
	a_ack_in_req: assert property (@(posedge clk) disable iff (reset)
		$rose(reg_ack) |-> $past(reg_in.req));

endmodule

// ==== design/ids.sv ====
`timescale 1ns/1ns

module ids import ids_pkt_pkg::*, ids_reg_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  pkt_word_t                 in_word,
	input  logic                      in_wr,
	output logic                      in_rdy,
	output pkt_word_t                 out_word,
	output logic                      out_wr,
	input  logic                      out_rdy,
	input  reg_req_t                  reg_in,
	output logic                      reg_ack,
	output logic [REG_DATA_WIDTH-1:0] reg_rdata
);

	pkt_word_t                  fifo_head;
	logic                       fifo_empty;
	logic                       fifo_nearly_full;
	logic                       fifo_rd_en;
	logic [DATA_WIDTH-1:0]      scan_word;
	logic                       scan_valid;
	logic                       pkt_end;
	logic                       lookup;
	ip_addr_t                   lookup_ip;
	logic [PATTERN_BYTES*8-1:0] pattern;
	logic                       pattern_hit;
	ft_write_t                  ft_wr;
	logic [FT_ADDR_WIDTH-1:0]   count_sel;
	logic [REG_DATA_WIDTH-1:0]  entry_count;
	logic [REG_DATA_WIDTH-1:0]  hit_total;

	assign in_rdy = !fifo_nearly_full;

	ids_input_fifo input_fifo (.clk(clk), .reset(reset), .wr_word(in_word), .wr_en(in_wr),
		.rd_en(fifo_rd_en), .head(fifo_head), .empty(fifo_empty),
		.nearly_full(fifo_nearly_full));

	ids_pkt_parser parser (.clk(clk), .reset(reset), .head(fifo_head), .empty(fifo_empty),
		.rd_en(fifo_rd_en), .out_rdy(out_rdy), .out_word(out_word), .out_wr(out_wr),
		.scan_word(scan_word), .scan_valid(scan_valid), .pkt_end(pkt_end),
		.lookup(lookup), .lookup_ip(lookup_ip));

	ids_pattern_matcher matcher (.clk(clk), .reset(reset), .pattern(pattern),
		.scan_word(scan_word), .scan_valid(scan_valid), .pkt_end(pkt_end),
		.pattern_hit(pattern_hit));

	ids_flow_table flow_table (.clk(clk), .reset(reset), .ft_wr(ft_wr), .lookup(lookup),
		.lookup_ip(lookup_ip), .count_sel(count_sel), .entry_count(entry_count),
		.hit_total(hit_total));

	ids_regs regs (.clk(clk), .reset(reset), .reg_in(reg_in), .reg_ack(reg_ack),
		.reg_rdata(reg_rdata), .pattern(pattern), .ft_wr(ft_wr), .count_sel(count_sel),
		.pkt_end(pkt_end), .pattern_hit(pattern_hit), .entry_count(entry_count),
		.hit_total(hit_total));

endmodule

// ==== testbench/ids_tb.sv ====
`timescale 1ns/1ns

module ids_tb import ids_pkt_pkg::*, ids_reg_pkg::*; ();

	// 12 packets of up to 20 words under back-pressure plus about 90 handshakes
	// take some 2000 cycles, so this is roughly ten times that
	localparam int TIMEOUT_CYCLES = 20000;

	localparam ip_addr_t IP_A = 32'h0a00_0001;
	localparam ip_addr_t IP_B = 32'hc0a8_0105;
	localparam ip_addr_t IP_C = 32'hac10_0020;  // loaded but never valid
	localparam ip_addr_t IP_D = 32'h0808_0808;
	localparam ip_addr_t IP_E = 32'h7f00_0001;  // not in the table

	logic                       clk;
	logic                       reset;
	pkt_word_t                  in_word;
	logic                       in_wr;
	logic                       in_rdy;
	pkt_word_t                  out_word;
	logic                       out_wr;
	logic                       out_rdy;
	reg_req_t                   reg_in;
	logic                       reg_ack;
	logic [REG_DATA_WIDTH-1:0]  reg_rdata;

	integer                     seed = 32'h193509e1;
	int                         cycles = 0;
	int                         fifo_level = 0;  // input FIFO words plus the one being read
	pkt_word_t                  sb_q [$];  // words sent, oldest first
	pkt_word_t                  exp_word;
	logic [PATTERN_BYTES*8-1:0] pat;
	ip_addr_t                   tb_ip [FT_DEPTH];
	logic                       tb_valid [FT_DEPTH];
	int                         exp_entry [FT_DEPTH];
	int                         exp_hits;
	int                         exp_matches;
	int                         pkts_sent;

	ids dut0 (.clk(clk), .reset(reset), .in_word(in_word), .in_wr(in_wr), .in_rdy(in_rdy),
		.out_word(out_word), .out_wr(out_wr), .out_rdy(out_rdy), .reg_in(reg_in),
		.reg_ack(reg_ack), .reg_rdata(reg_rdata));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_on_failure();
		$display("Testbench failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("error: run stopped after %0d cycles without finishing", cycles);
			stop_on_failure();
		end
	end

	// a word leaves the FIFO one cycle before it shows on out_wr
	always @(posedge clk) begin
		if (reset)
			fifo_level <= 0;
		else
			fifo_level <= fifo_level + int'(in_wr) - int'(out_wr);
	end

	// nearly full from three words on
	a_in_rdy: assert property (@(posedge clk) disable iff (reset)
		in_rdy == (fifo_level - int'(out_wr) < 3))
		else begin
			$display("error: %0t in_rdy expected %b got %b", $time, !$sampled(in_rdy),
				$sampled(in_rdy));
			stop_on_failure();
		end

	always @(negedge clk)
		out_rdy = ($random(seed) & 3) != 0;  // ready about three cycles in four

	// every word on out_wr must be the oldest one still pending
	always @(negedge clk) begin
		if (!reset && out_wr) begin
			assert (sb_q.size() != 0) else begin
				$display("error: %0t out_wr high with no word pending", $time);
				stop_on_failure();
			end
			exp_word = sb_q.pop_front();
			assert (out_word == exp_word) else begin
				$display("error: %0t out_word expected %h got %h", $time, exp_word, out_word);
				stop_on_failure();
			end
		end
	end

	a_ack_delay: assert property (@(posedge clk) disable iff (reset)
		$rose(reg_ack) |-> $past(reg_in.req, 2) && !$past(reg_in.req, 3))
		else begin
			$display("error: %0t reg_ack did not rise two cycles after req", $time);
			stop_on_failure();
		end

	a_ack_release: assert property (@(posedge clk) disable iff (reset)
		$fell(reg_in.req) |=> $fell(reg_ack))
		else begin
			$display("error: %0t reg_ack stayed high after req dropped", $time);
			stop_on_failure();
		end

	// one four-phase handshake, called on a falling edge
	task automatic bus_access(input logic rd, input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] wdata, output logic [REG_DATA_WIDTH-1:0] rdata);
		while (reg_ack)
			@(negedge clk);
		reg_in.rd_wr_l = rd;
		reg_in.addr    = addr;
		reg_in.wdata   = wdata;
		reg_in.req     = 1'b1;
		@(negedge clk);
		while (!reg_ack)
			@(negedge clk);
		rdata      = reg_rdata;
		reg_in.req = 1'b0;
		@(negedge clk);
	endtask

	task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] data);
		logic [REG_DATA_WIDTH-1:0] unused;
		bus_access(1'b0, addr, data, unused);
	endtask

	task automatic check_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] expected, input string name);
		logic [REG_DATA_WIDTH-1:0] got;
		bus_access(1'b1, addr, '0, got);
		assert (got == expected) else begin
			$display("error: %0t %s expected %h got %h", $time, name, expected, got);
			stop_on_failure();
		end
	endtask

	task automatic load_entry(input int index, input ip_addr_t ip, input logic valid);
		write_reg(REG_FT_IP, ip);
		check_reg(REG_FT_IP, ip, "REG_FT_IP");
		write_reg(REG_FT_ENTRY, {27'd0, valid, 4'(index)});
		check_reg(REG_FT_ENTRY, {27'd0, valid, 4'(index)}, "REG_FT_ENTRY");
		tb_ip[index]    = ip;
		tb_valid[index] = valid;
	endtask

	// holds in_wr low while in_rdy is low, so at most one late word
	task automatic push_word(input pkt_word_t w);
		while (!in_rdy) begin
			in_wr = 1'b0;
			@(negedge clk);
		end
		in_word = w;
		in_wr   = 1'b1;
		sb_q.push_back(w);
		@(negedge clk);
		in_wr = 1'b0;
	endtask

	// plain search over the payload byte stream
	function automatic logic has_pattern(input logic [7:0] bytes_q [$]);
		logic found;
		int   n;
		found = 1'b0;
		for (int s = 0; s + PATTERN_BYTES <= bytes_q.size(); s++) begin
			n = 0;
			for (int k = 0; k < PATTERN_BYTES; k++)
				if (bytes_q[s+k] == pat[PATTERN_BYTES*8-1-8*k -: 8])
					n++;
			if (n == PATTERN_BYTES)
				found = 1'b1;
		end
		return found;
	endfunction

	// pos1, pos2 are payload byte offsets of the pattern, -1 for none
	task automatic send_packet(input ip_addr_t ip, input int n_payload, input int pos1,
		input int pos2, input logic hdr_pat);
		logic [7:0] payload [$];
		pkt_word_t  w;
		logic       any_hit;
		payload = {};
		for (int b = 0; b < 8 * n_payload; b++)
			payload.push_back(8'($random(seed)));
		for (int k = 0; k < PATTERN_BYTES; k++) begin
			if (pos1 >= 0)
				payload[pos1+k] = pat[PATTERN_BYTES*8-1-8*k -: 8];
			if (pos2 >= 0)
				payload[pos2+k] = pat[PATTERN_BYTES*8-1-8*k -: 8];
		end
		push_word({8'hff, $random(seed), $random(seed)});  // start word
		for (int h = 1; h <= HDR_WORDS; h++) begin
			w.ctrl = '0;
			w.data = {$random(seed), $random(seed)};
			if (h == IP_WORD)
				w.data[IP_LSB +: 32] = ip;
			if (hdr_pat && h == 2)
				w.data[63:8] = pat;  // header copy, not payload
			push_word(w);
		end
		for (int i = 0; i < n_payload; i++) begin
			w.ctrl = '0;
			for (int k = 0; k < 8; k++)
				w.data[63-8*k -: 8] = payload[8*i+k];
			push_word(w);
		end
		push_word({8'h01, 64'h0});  // end word
		pkts_sent++;
		if (has_pattern(payload))
			exp_matches++;
		any_hit = 1'b0;
		for (int i = 0; i < FT_DEPTH; i++) begin
			if (tb_valid[i] && tb_ip[i] == ip) begin
				exp_entry[i]++;
				any_hit = 1'b1;
			end
		end
		if (any_hit)
			exp_hits++;
	endtask

	initial begin
		reset       = 1'b1;
		in_word     = '0;
		in_wr       = 1'b0;
		out_rdy     = 1'b0;
		reg_in      = '0;
		pat         = 56'h5a_c3_96_e1_0f_7b_24;
		exp_hits    = 0;
		exp_matches = 0;
		pkts_sent   = 0;
		for (int i = 0; i < FT_DEPTH; i++) begin
			tb_ip[i]     = '0;
			tb_valid[i]  = 1'b0;
			exp_entry[i] = 0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (!out_wr && !reg_ack) else begin
			$display("error: %0t out_wr or reg_ack high after reset", $time);
			stop_on_failure();
		end
		for (int a = 0; a < 16; a++)
			check_reg(4'(a), '0, $sformatf("register %0d after reset", a));

		write_reg(REG_PATTERN_HIGH, {8'hee, pat[55:32]});  // top byte ignored
		write_reg(REG_PATTERN_LOW, pat[31:0]);
		check_reg(REG_PATTERN_HIGH, {8'hee, pat[55:32]}, "REG_PATTERN_HIGH");
		check_reg(REG_PATTERN_LOW, pat[31:0], "REG_PATTERN_LOW");
		load_entry(0, IP_A, 1'b1);
		load_entry(3, IP_B, 1'b1);
		load_entry(7, IP_C, 1'b0);
		load_entry(9, IP_A, 1'b1);  // same ip twice
		load_entry(15, IP_D, 1'b1);

		send_packet(IP_A, 3, -1, -1, 1'b0);
		send_packet(IP_B, 4, 8, -1, 1'b0);   // inside one word
		send_packet(IP_C, 2, -1, -1, 1'b0);
		send_packet(IP_A, 5, 12, -1, 1'b0);  // across two words
		send_packet(IP_D, 6, 3, 30, 1'b0);   // twice
		send_packet(IP_E, 3, -1, -1, 1'b1);  // header only
		send_packet(IP_A, 13, 97, -1, 1'b0);
		send_packet(IP_B, 1, 1, -1, 1'b0);
		send_packet(IP_D, 0, -1, -1, 1'b0);  // no payload
		send_packet(IP_E, 2, 6, -1, 1'b0);
		send_packet(IP_C, 4, 16, -1, 1'b1);
		send_packet(IP_A, 7, -1, -1, 1'b0);

		while (sb_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);  // counters settle
		check_reg(REG_NUM_PACKETS, pkts_sent, "REG_NUM_PACKETS");
		check_reg(REG_PATTERN_MATCHES, exp_matches, "REG_PATTERN_MATCHES");
		check_reg(REG_FLOW_HITS, exp_hits, "REG_FLOW_HITS");
		for (int i = 0; i < FT_DEPTH; i++) begin
			write_reg(REG_COUNT_SEL, i);
			check_reg(REG_COUNT_SEL, i, "REG_COUNT_SEL");
			check_reg(REG_ENTRY_COUNT, exp_entry[i], $sformatf("REG_ENTRY_COUNT[%0d]", i));
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== ids.f ====
design/ids_pkt_pkg.sv
design/ids_reg_pkg.sv
design/ids_input_fifo.sv
design/ids_pkt_parser.sv
design/ids_pattern_matcher.sv
design/ids_flow_table.sv
design/ids_regs.sv
design/ids.sv
testbench/ids_tb.sv

// ==== run_ids.sh ====
#!/usr/bin/env bash
# build the ids testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ids_tb -f ids.f -o ids_sim &&
./obj_dir/ids_sim | tee /dev/stderr | grep -qx "Testbench passed" &&
echo "ids: run passed" ||
{ echo "ids: run failed"; exit 1; }
